/* data_memory.hex */
// one 32-bit word per line in hex, memory word 0 first
// words 0 to 15 back the code region, words 16 to 31 the data region
C020A040
319151E1
C222A242
339353E3
C424A444
359555E5
C626A646
379757E7
C828A848
399959E9
CA2AAA4A
3B9B5BEB
CC2CAC4C
3D9D5DED
CE2EAE4E
3F9F5FEF
D030B050
41A161F1
D232B252
43A363F3
D434B454
45A565F5
D636B656
47A767F7
D838B858
49A969F9
DA3ABA5A
4BAB6BFB
DC3CBC5C
4DAD6DFD
DE3EBE5E
4FAF6FFF

/* sim.f */
hdl/load_pkg.sv
hdl/load_dispatcher.sv
hdl/load_unit.sv
hdl/data_memory.sv
hdl/result_collector.sv
hdl/load_subsystem.sv
sim/load_subsystem_asserts.sv
sim/tb_load_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the load subsystem testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_load_subsystem -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_load_subsystem +verilator+error+limit+1000)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

/* sim/tb_load_subsystem.sv */
`timescale 1ns/1ps

module tb_load_subsystem;

    localparam int        NUM_DIRECTED   = 41;   // requests of tests 1 to 3.
    localparam int        NUM_RANDOM     = 40;
    localparam int        NUM_BACKPRESS  = 10;
    localparam int        TIMEOUT_CYCLES = 200 * (NUM_DIRECTED + NUM_RANDOM + NUM_BACKPRESS) + 100;
    localparam int        ACK_DELAY_MAX  = 8;
    localparam bit [31:0] SEED           = 32'h8bb1;

    logic               clk;
    logic               rst_n;
    logic               req;
    load_pkg::addr_t    addr;
    load_pkg::load_op_t op;
    load_pkg::tag_t     tag;
    logic               ack;
    logic               rsp_req;
    load_pkg::word_t    rsp_data;
    logic               rsp_fault;
    load_pkg::tag_t     rsp_tag;
    logic               rsp_ack;

    load_pkg::word_t model_mem [32];
    load_pkg::word_t exp_data  [16];
    logic            exp_fault [16];
    logic [15:0]     pending;          // one bit per tag still in flight.
    load_pkg::tag_t  next_tag;
    logic            slow_rsp;
    int              max_ack_wait;
    int              cycle_cnt;
    int              err_cnt;
    int              test_err_start;
    int              tests_passed;
    int              tests_failed;

    load_subsystem i_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .addr_i      (addr),
        .op_i        (op),
        .tag_i       (tag),
        .ack_o       (ack),
        .rsp_req_o   (rsp_req),
        .rsp_data_o  (rsp_data),
        .rsp_fault_o (rsp_fault),
        .rsp_tag_o   (rsp_tag),
        .rsp_ack_i   (rsp_ack)
    );

    bind load_subsystem load_subsystem_asserts i_asserts (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .ack_i        (ack_o),
        .rsp_req_i    (rsp_req_o),
        .rsp_data_i   (rsp_data_o),
        .rsp_fault_i  (rsp_fault_o),
        .rsp_tag_i    (rsp_tag_o),
        .rsp_ack_i    (rsp_ack_i),
        .lane_start_i (lane_start),
        .lane_idle_i  (lane_idle)
    );

    always #2 clk = ~clk;

    // Reference model. Code words sit at 0x0000 to 0x003F and data words at 0x1000 to 0x103F,
    // so both regions are whole 64-byte blocks, and the word index is bit 12 then bits 5 to 2.
    function automatic void expected_load(input load_pkg::addr_t a, input load_pkg::load_op_t o,
                                          output load_pkg::word_t data, output logic fault);
        logic            mapped;
        logic            misaligned;
        load_pkg::word_t word;
        logic [7:0]      byte_val;
        logic [15:0]     half_val;

        mapped     = (a[31:6] == 26'h0) || (a[31:6] == 26'h40);
        misaligned = 1'b0;
        if (o == load_pkg::LOAD_LH || o == load_pkg::LOAD_LHU) begin
            misaligned = a[0];
        end else if (o == load_pkg::LOAD_LW) begin
            misaligned = (a[1:0] != 2'b00);
        end
        fault    = !mapped || misaligned;
        word     = model_mem[{a[12], a[5:2]}];
        byte_val = word[{a[1:0], 3'b000} +: 8];
        half_val = a[1] ? word[31:16] : word[15:0];
        data     = '0;   // a fault always returns zero.
        if (!fault) begin
            case (o)
                load_pkg::LOAD_LB:  data = {{24{byte_val[7]}}, byte_val};
                load_pkg::LOAD_LBU: data = {24'h0, byte_val};
                load_pkg::LOAD_LH:  data = {{16{half_val[15]}}, half_val};
                load_pkg::LOAD_LHU: data = {16'h0, half_val};
                default:            data = word;
            endcase
        end
    endfunction

    task automatic issue_load(input load_pkg::addr_t a, input load_pkg::load_op_t o);
        load_pkg::tag_t t;
        int             wait_cycles;

        t        = next_tag;
        next_tag = next_tag + 1'b1;
        while (pending[t]) begin
            @(negedge clk);   // the old request with this tag has not returned yet.
        end
        expected_load(a, o, exp_data[t], exp_fault[t]);
        pending[t] = 1'b1;
        addr = a;
        op   = o;
        tag  = t;
        req  = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!ack);
        req = 1'b0;
        if (wait_cycles > max_ack_wait) begin
            max_ack_wait = wait_cycles;
        end
        do begin
            @(negedge clk);
        end while (ack);
    endtask

    task automatic check_response(input load_pkg::tag_t t, input load_pkg::word_t d,
                                  input logic f);
        if (!pending[t]) begin
            $display("ERROR at %t: a response came back with tag %0d, which was not outstanding",
                     $realtime, t);
            err_cnt++;
        end else begin
            assert ((d == exp_data[t]) && (f == exp_fault[t])) else begin
                $display("FAIL at %t: tag %0d returned data %h fault %b, expected %h fault %b",
                         $realtime, t, d, f, exp_data[t], exp_fault[t]);
                err_cnt++;
            end
            pending[t] = 1'b0;
        end
    endtask

    task automatic begin_test();
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        while (pending != '0) begin
            @(negedge clk);
        end
        if (err_cnt == test_err_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_err_start);
        end
    endtask

    // the response side acks after a random delay and checks each result by its tag.
    initial begin : responder
        int delay;

        rsp_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (rsp_req) begin
                delay = slow_rsp ? int'($urandom_range(40, 30))
                                 : int'($urandom_range(ACK_DELAY_MAX, 0));
                repeat (delay) @(negedge clk);
                check_response(rsp_tag, rsp_data, rsp_fault);
                rsp_ack = 1'b1;
                do begin
                    @(negedge clk);
                end while (rsp_req);
                rsp_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d responses never came back",
                 cycle_cnt, $countones(pending));
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        load_pkg::addr_t base;
        int              sel;

        $timeformat(-9, 1, " ns", 0);
        void'($urandom(SEED));
        $readmemh("data_memory.hex", model_mem);
        clk = 1'b0;
        rst_n = 1'b0;
        req = 1'b0;
        addr = '0;
        op = load_pkg::LOAD_LW;
        tag = '0;
        pending = '0;
        next_tag = '0;
        slow_rsp = 1'b0;
        max_ack_wait = 0;
        err_cnt = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        begin_test();
        issue_load(32'h0000_0000, load_pkg::LOAD_LW);
        issue_load(32'h0000_0020, load_pkg::LOAD_LW);
        issue_load(32'h0000_003C, load_pkg::LOAD_LW);
        issue_load(32'h0000_1000, load_pkg::LOAD_LW);
        issue_load(32'h0000_1024, load_pkg::LOAD_LW);
        issue_load(32'h0000_103C, load_pkg::LOAD_LW);
        end_test("aligned word loads");

        // word 5 has positive halves, word 18 negative ones, and bytes of both signs.
        begin_test();
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? 32'h0000_0014 : 32'h0000_1008;
            for (int off = 0; off < 4; off++) begin
                issue_load(base + off, load_pkg::LOAD_LB);
                issue_load(base + off, load_pkg::LOAD_LBU);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_load(base + off, load_pkg::LOAD_LH);
                issue_load(base + off, load_pkg::LOAD_LHU);
            end
        end
        end_test("byte and half extension");

        begin_test();
        issue_load(32'h0000_0004, load_pkg::LOAD_LW);
        issue_load(32'h0000_0040, load_pkg::LOAD_LW);    // one past the code region.
        issue_load(32'h0000_0FFC, load_pkg::LOAD_LW);
        issue_load(32'h0000_103F, load_pkg::LOAD_LBU);
        issue_load(32'h0000_1040, load_pkg::LOAD_LW);
        issue_load(32'hFFFF_FFFF, load_pkg::LOAD_LB);
        issue_load(32'h0000_0005, load_pkg::LOAD_LH);
        issue_load(32'h0000_003E, load_pkg::LOAD_LH);
        issue_load(32'h0000_1023, load_pkg::LOAD_LHU);
        issue_load(32'h0000_1002, load_pkg::LOAD_LW);
        issue_load(32'h0000_0001, load_pkg::LOAD_LW);
        end_test("faults and neighbors");

        begin_test();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            sel = int'($urandom % 8);
            if (sel < 3) begin
                base = 32'h0000_0000 + ($urandom % 64);
            end else if (sel < 6) begin
                base = 32'h0000_1000 + ($urandom % 64);
            end else if (sel == 6) begin
                base = 32'h0000_0040 + ($urandom % 32'h0FC0);   // the gap between regions.
            end else begin
                base = $urandom;
            end
            case ($urandom % 5)
                0:       issue_load(base, load_pkg::LOAD_LB);
                1:       issue_load(base, load_pkg::LOAD_LBU);
                2:       issue_load(base, load_pkg::LOAD_LH);
                3:       issue_load(base, load_pkg::LOAD_LHU);
                default: issue_load(base, load_pkg::LOAD_LW);
            endcase
        end
        end_test("random back to back");

        // a slow consumer fills every lane, so later requests must wait for their ack.
        begin_test();
        slow_rsp = 1'b1;
        max_ack_wait = 0;
        for (int n = 0; n < NUM_BACKPRESS; n++) begin
            issue_load(32'h0000_1000 + 4 * n,
                       (n % 2 == 0) ? load_pkg::LOAD_LW : load_pkg::LOAD_LB);
        end
        while (pending != '0) begin
            @(negedge clk);
        end
        assert (max_ack_wait >= 10) else begin
            $display("FAIL at %t: request ack never stalled, longest wait %0d cycles",
                     $realtime, max_ack_wait);
            err_cnt++;
        end
        slow_rsp = 1'b0;
        end_test("back-pressure");

        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, i_dut.i_asserts.fail_cnt);
        if ((tests_failed == 0) && (i_dut.i_asserts.fail_cnt == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_load_subsystem

/* sim/load_subsystem_asserts.sv */
`timescale 1ns/1ps

module load_subsystem_asserts (
    input logic                             clk_i,
    input logic                             rst_n_i,
    input logic                             req_i,
    input logic                             ack_i,
    input logic                             rsp_req_i,
    input load_pkg::word_t                  rsp_data_i,
    input logic                             rsp_fault_i,
    input load_pkg::tag_t                   rsp_tag_i,
    input logic                             rsp_ack_i,
    input logic [load_pkg::NUM_LANES - 1:0] lane_start_i,
    input logic [load_pkg::NUM_LANES - 1:0] lane_idle_i
);

    int ack_fail   = 0;
    int hold_fail  = 0;
    int reset_fail = 0;
    int start_fail = 0;
    int fail_cnt;

    assign fail_cnt = ack_fail + hold_fail + reset_fail + start_fail;

    // ack rises on the edge after req was sampled high.
    ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose without a pending request");
            ack_fail++;
        end

    rsp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rsp_req_i && !rsp_ack_i) |=> (rsp_req_i && $stable(rsp_data_i)
                                       && $stable(rsp_fault_i) && $stable(rsp_tag_i)))
        else begin
            $error("response request dropped or changed before its ack");
            hold_fail++;
        end

    rsp_low_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !rsp_req_i)
        else begin
            $error("response request high right after reset");
            reset_fail++;
        end

    // a start pulse goes to one lane only, and that lane must still be idle.
    one_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(lane_start_i) && ((lane_start_i & ~lane_idle_i) == '0))
        else begin
            $error("more than one lane started in one cycle, or a busy lane was started");
            start_fail++;
        end

endmodule : load_subsystem_asserts

/* hdl/load_subsystem.sv */
`timescale 1ns/1ps

module load_subsystem (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  load_pkg::addr_t    addr_i,
    input  load_pkg::load_op_t op_i,
    input  load_pkg::tag_t     tag_i,
    output logic               ack_o,

    output logic               rsp_req_o,
    output load_pkg::word_t    rsp_data_o,
    output logic               rsp_fault_o,
    output load_pkg::tag_t     rsp_tag_o,
    input  logic               rsp_ack_i
);

    // dispatcher to lanes.
    logic               [load_pkg::NUM_LANES - 1:0] lane_idle;
    logic               [load_pkg::NUM_LANES - 1:0] lane_start;
    load_pkg::addr_t                                lane_addr;
    load_pkg::load_op_t                             lane_op;
    load_pkg::tag_t                                 lane_tag;

    // lanes to memory.
    logic               [load_pkg::NUM_LANES - 1:0] mem_read;
    load_pkg::addr_t    [load_pkg::NUM_LANES - 1:0] mem_addr;
    logic               [load_pkg::NUM_LANES - 1:0] mem_data_valid;
    load_pkg::word_t                                mem_data;

    // lanes to collector.
    logic               [load_pkg::NUM_LANES - 1:0] result_valid;
    load_pkg::word_t    [load_pkg::NUM_LANES - 1:0] result_data;
    logic               [load_pkg::NUM_LANES - 1:0] result_fault;
    load_pkg::tag_t     [load_pkg::NUM_LANES - 1:0] result_tag;
    logic               [load_pkg::NUM_LANES - 1:0] result_take;

    load_dispatcher i_dispatcher (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .op_i         (op_i),
        .tag_i        (tag_i),
        .lane_idle_i  (lane_idle),
        .ack_o        (ack_o),
        .lane_start_o (lane_start),
        .lane_addr_o  (lane_addr),
        .lane_op_o    (lane_op),
        .lane_tag_o   (lane_tag)
    );

    // every lane sees the same request fields, only its start pulse differs.
    for (genvar g = 0; g < load_pkg::NUM_LANES; g++) begin : gen_lane
        load_unit i_load_unit (
            .clk_i            (clk_i),
            .rst_n_i          (rst_n_i),
            .start_i          (lane_start[g]),
            .addr_i           (lane_addr),
            .op_i             (lane_op),
            .tag_i            (lane_tag),
            .mem_data_valid_i (mem_data_valid[g]),
            .mem_data_i       (mem_data),
            .result_take_i    (result_take[g]),
            .idle_o           (lane_idle[g]),
            .mem_read_o       (mem_read[g]),
            .mem_addr_o       (mem_addr[g]),
            .result_valid_o   (result_valid[g]),
            .result_data_o    (result_data[g]),
            .result_fault_o   (result_fault[g]),
            .result_tag_o     (result_tag[g])
        );
    end

    data_memory i_data_memory (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .mem_read_i       (mem_read),
        .mem_addr_i       (mem_addr),
        .mem_data_valid_o (mem_data_valid),
        .mem_data_o       (mem_data)
    );

    result_collector i_result_collector (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .result_valid_i (result_valid),
        .result_data_i  (result_data),
        .result_fault_i (result_fault),
        .result_tag_i   (result_tag),
        .rsp_ack_i      (rsp_ack_i),
        .result_take_o  (result_take),
        .rsp_req_o      (rsp_req_o),
        .rsp_data_o     (rsp_data_o),
        .rsp_fault_o    (rsp_fault_o),
        .rsp_tag_o      (rsp_tag_o)
    );

endmodule : load_subsystem

/* hdl/result_collector.sv */
`timescale 1ns/1ps

module result_collector (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic            [load_pkg::NUM_LANES - 1:0] result_valid_i,
    input  load_pkg::word_t [load_pkg::NUM_LANES - 1:0] result_data_i,
    input  logic            [load_pkg::NUM_LANES - 1:0] result_fault_i,
    input  load_pkg::tag_t  [load_pkg::NUM_LANES - 1:0] result_tag_i,
    input  logic                                        rsp_ack_i,

    output logic            [load_pkg::NUM_LANES - 1:0] result_take_o,
    output logic                                        rsp_req_o,
    output load_pkg::word_t                             rsp_data_o,
    output logic                                        rsp_fault_o,
    output load_pkg::tag_t                              rsp_tag_o
);

    typedef enum logic [1:0] {PICK, WAIT_ACK, WAIT_RELEASE} coll_state_t;

    coll_state_t                      state;
    load_pkg::lane_idx_t              pick_idx;
    logic [load_pkg::NUM_LANES - 1:0] take_sel;

    // lowest-numbered valid lane wins.
    always_comb begin
        pick_idx = '0;
        for (int i = load_pkg::NUM_LANES - 1; i >= 0; i--) begin
            if (result_valid_i[i]) begin
                pick_idx = load_pkg::lane_idx_t'(i);
            end
        end

        take_sel = '0;
        take_sel[pick_idx] = 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state         <= PICK;
            result_take_o <= '0;
            rsp_req_o     <= 1'b0;
        end else begin
            result_take_o <= '0;

            case (state)
                PICK: begin
                    if (|result_valid_i) begin
                        state         <= WAIT_ACK;
                        result_take_o <= take_sel;
                    end
                end

                WAIT_ACK: begin
                    if (rsp_req_o && rsp_ack_i) begin
                        state     <= WAIT_RELEASE;
                        rsp_req_o <= 1'b0;
                    end else begin
                        rsp_req_o <= 1'b1;   // rises the cycle after the take pulse.
                    end
                end

                WAIT_RELEASE: begin
                    if (!rsp_ack_i) begin
                        state <= PICK;
                    end
                end

                default: state <= PICK;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == PICK) && (|result_valid_i)) begin
            rsp_data_o  <= result_data_i[pick_idx];
            rsp_fault_o <= result_fault_i[pick_idx];
            rsp_tag_o   <= result_tag_i[pick_idx];
        end
    end

endmodule : result_collector

/* hdl/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic            [load_pkg::NUM_LANES - 1:0] mem_read_i,
    input  load_pkg::addr_t [load_pkg::NUM_LANES - 1:0] mem_addr_i,

    output logic            [load_pkg::NUM_LANES - 1:0] mem_data_valid_o,
    output load_pkg::word_t                             mem_data_o
);

    load_pkg::word_t mem [load_pkg::MEM_WORDS];

    logic                                         busy;
    logic [$clog2(load_pkg::MEM_LATENCY + 1) - 1:0] lat_cnt;
    load_pkg::lane_idx_t                          cur_lane;
    load_pkg::lane_idx_t                          last_grant;
    logic [$clog2(load_pkg::MEM_WORDS) - 1:0]     rd_idx;
    logic [load_pkg::NUM_LANES - 1:0]             pending;
    load_pkg::lane_idx_t                          grant_idx;
    logic                                         grant_found;
    logic [load_pkg::NUM_LANES - 1:0]             valid_sel;

    initial begin
        $readmemh("data_memory.hex", mem);
    end

    // A lane keeps mem_read high during its own valid pulse, so that lane
    // must not be granted a second time.
    assign pending = mem_read_i & ~mem_data_valid_o;

    // round-robin search that starts just after the last granted lane.
    always_comb begin
        grant_idx   = last_grant;
        grant_found = 1'b0;
        for (int i = 1; i <= load_pkg::NUM_LANES; i++) begin
            if (!grant_found && pending[load_pkg::lane_idx_t'(last_grant + i)]) begin
                grant_idx   = load_pkg::lane_idx_t'(last_grant + i);
                grant_found = 1'b1;
            end
        end

        valid_sel = '0;
        valid_sel[cur_lane] = 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy             <= 1'b0;
            lat_cnt          <= '0;
            cur_lane         <= '0;
            last_grant       <= load_pkg::lane_idx_t'(load_pkg::NUM_LANES - 1);
            mem_data_valid_o <= '0;
        end else begin
            mem_data_valid_o <= '0;

            if (!busy) begin
                if (grant_found) begin
                    busy       <= 1'b1;
                    lat_cnt    <= '0;
                    cur_lane   <= grant_idx;
                    last_grant <= grant_idx;
                end
            end else if (int'(lat_cnt) == load_pkg::MEM_LATENCY - 1) begin
                busy             <= 1'b0;
                mem_data_valid_o <= valid_sel;   // only the served lane sees it.
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    // the word index is latched with the grant and the word read at the end.
    always_ff @(posedge clk_i) begin
        if (!busy && grant_found) begin
            rd_idx <= {mem_addr_i[grant_idx][12], mem_addr_i[grant_idx][5:2]};
        end

        if (busy && (int'(lat_cnt) == load_pkg::MEM_LATENCY - 1)) begin
            mem_data_o <= mem[rd_idx];
        end
    end

endmodule : data_memory

/* hdl/load_unit.sv */
`timescale 1ns/1ps

module load_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  load_pkg::addr_t    addr_i,
    input  load_pkg::load_op_t op_i,
    input  load_pkg::tag_t     tag_i,
    input  logic               mem_data_valid_i,
    input  load_pkg::word_t    mem_data_i,
    input  logic               result_take_i,

    output logic               idle_o,
    output logic               mem_read_o,
    output load_pkg::addr_t    mem_addr_o,
    output logic               result_valid_o,
    output load_pkg::word_t    result_data_o,
    output logic               result_fault_o,
    output load_pkg::tag_t     result_tag_o
);

    typedef enum logic [1:0] {IDLE, WAIT_MEM, RESULT} lane_state_t;

    lane_state_t        state;
    load_pkg::addr_t    addr_q;
    load_pkg::load_op_t op_q;
    logic               mapped;
    logic               misaligned;
    logic               take_start;
    load_pkg::word_t    shifted;
    load_pkg::word_t    extracted;

    function automatic logic in_range(
        input load_pkg::addr_t lo,
        input load_pkg::addr_t hi,
        input load_pkg::addr_t addr
    );
        return (addr >= lo) && (addr <= hi);
    endfunction

    assign take_start = start_i && (state == IDLE);
    assign idle_o     = (state == IDLE);
    assign mem_addr_o = addr_q;

    // the fault is decided on the incoming request, in the start cycle.
    always_comb begin
        mapped = in_range(load_pkg::CODE_REGION_START, load_pkg::CODE_REGION_END, addr_i)
               | in_range(load_pkg::DATA_REGION_START, load_pkg::DATA_REGION_END, addr_i);

        case (op_i)
            load_pkg::LOAD_LB, load_pkg::LOAD_LBU: misaligned = 1'b0;
            load_pkg::LOAD_LH, load_pkg::LOAD_LHU: misaligned = addr_i[0];
            load_pkg::LOAD_LW:                     misaligned = |addr_i[1:0];
            default:                               misaligned = 1'b1;   // unknown code.
        endcase
    end

    /*
     * The returned word is shifted right by the byte offset, so the wanted
     * byte or half always sits in the low bits before it is extended.
     */
    always_comb begin
        shifted = mem_data_i >> {addr_q[1:0], 3'b000};

        case (op_q)
            load_pkg::LOAD_LB:  extracted = {{24{shifted[7]}}, shifted[7:0]};
            load_pkg::LOAD_LBU: extracted = {24'b0, shifted[7:0]};
            load_pkg::LOAD_LH:  extracted = {{16{shifted[15]}}, shifted[15:0]};
            load_pkg::LOAD_LHU: extracted = {16'b0, shifted[15:0]};
            default:            extracted = mem_data_i;   // LW, the only other legal code.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state          <= IDLE;
            mem_read_o     <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) begin
                        if (mapped && !misaligned) begin
                            state      <= WAIT_MEM;
                            mem_read_o <= 1'b1;
                        end else begin
                            // a faulting access never reaches the memory.
                            state          <= RESULT;
                            result_valid_o <= 1'b1;
                        end
                    end
                end

                WAIT_MEM: begin
                    if (mem_data_valid_i) begin
                        state          <= RESULT;
                        mem_read_o     <= 1'b0;
                        result_valid_o <= 1'b1;
                    end
                end

                RESULT: begin
                    // the lane stays busy until the collector takes the result.
                    if (result_take_i) begin
                        state          <= IDLE;
                        result_valid_o <= 1'b0;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_start) begin
            addr_q         <= addr_i;
            op_q           <= op_i;
            result_tag_o   <= tag_i;
            result_fault_o <= !mapped || misaligned;
            result_data_o  <= '0;   // stays zero on a fault.
        end else if ((state == WAIT_MEM) && mem_data_valid_i) begin
            result_data_o <= extracted;
        end
    end

endmodule : load_unit

/* hdl/load_dispatcher.sv */
`timescale 1ns/1ps

module load_dispatcher (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  load_pkg::addr_t                  addr_i,
    input  load_pkg::load_op_t               op_i,
    input  load_pkg::tag_t                   tag_i,
    input  logic [load_pkg::NUM_LANES - 1:0] lane_idle_i,

    output logic                             ack_o,
    output logic [load_pkg::NUM_LANES - 1:0] lane_start_o,
    output load_pkg::addr_t                  lane_addr_o,
    output load_pkg::load_op_t               lane_op_o,
    output load_pkg::tag_t                   lane_tag_o
);

    typedef enum logic {WAIT_REQ, WAIT_RELEASE} disp_state_t;

    disp_state_t                      state;
    load_pkg::lane_idx_t              pick_idx;
    logic [load_pkg::NUM_LANES - 1:0] start_sel;
    logic                             any_idle;

    assign any_idle = |lane_idle_i;

    // priority pick of the lowest idle lane, the last match in the loop wins.
    always_comb begin
        pick_idx = '0;
        for (int i = load_pkg::NUM_LANES - 1; i >= 0; i--) begin
            if (lane_idle_i[i]) begin
                pick_idx = load_pkg::lane_idx_t'(i);
            end
        end

        start_sel = '0;
        start_sel[pick_idx] = 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state        <= WAIT_REQ;
            ack_o        <= 1'b0;
            lane_start_o <= '0;
        end else begin
            lane_start_o <= '0;   // the start is a single cycle pulse.

            case (state)
                WAIT_REQ: begin
                    // with every lane busy the ack is withheld.
                    if (req_i && any_idle) begin
                        state        <= WAIT_RELEASE;
                        ack_o        <= 1'b1;
                        lane_start_o <= start_sel;
                    end
                end

                WAIT_RELEASE: begin
                    if (!req_i) begin
                        state <= WAIT_REQ;
                        ack_o <= 1'b0;
                    end
                end
            endcase
        end
    end

    // The request fields are stable while req_i is high, so they are sampled
    // on every cycle spent waiting and hold once the request is taken.
    always_ff @(posedge clk_i) begin
        if (state == WAIT_REQ) begin
            lane_addr_o <= addr_i;
            lane_op_o   <= op_i;
            lane_tag_o  <= tag_i;
        end
    end

endmodule : load_dispatcher

/* hdl/load_pkg.sv */
package load_pkg;

    // basic datapath widths of the load subsystem.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  tag_t;

    // the load operation follows the RV32 funct3 encoding of the load opcode.
    typedef logic [2:0]  load_op_t;

    localparam load_op_t LOAD_LB  = 3'b000;
    localparam load_op_t LOAD_LH  = 3'b001;
    localparam load_op_t LOAD_LW  = 3'b010;
    localparam load_op_t LOAD_LBU = 3'b100;
    localparam load_op_t LOAD_LHU = 3'b101;

    // number of identical load units behind the dispatcher.
    localparam int NUM_LANES = 4;

    typedef logic [1:0]  lane_idx_t;

    // shared data memory size and read latency.
    localparam int MEM_WORDS   = 32;
    localparam int MEM_LATENCY = 2;   // cycles from grant to data valid.

    /*
     * Core memory map. The code region holds memory words 0 to 15 and the
     * data region words 16 to 31, so the word index is address bit 12
     * followed by address bits 5 to 2.
     */
    localparam addr_t CODE_REGION_START = 32'h0000_0000;
    localparam addr_t CODE_REGION_END   = 32'h0000_003F;

    localparam addr_t DATA_REGION_START = 32'h0000_1000;
    localparam addr_t DATA_REGION_END   = 32'h0000_103F;

endpackage : load_pkg
